//--- flist.f
+incdir+include
design/packer_pkg.sv
design/dual_port_ram.sv
design/fifo_sync.sv
design/byte_ingress.sv
design/word_packer.sv
design/stream_packer_top.sv
tb/stream_packer_sva.sv
tb/tb_stream_packer.sv

//--- Makefile
# Verilator build and regression run for the stream packer testbench
VERILATOR ?= verilator
TOP       ?= tb_stream_packer
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
	   echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_stream_packer.sv
// self-checking testbench for the stream packer, seeded random stimulus against a packing model
`timescale 1ns/1ps
`include "packer_consts.svh"

module tb_stream_packer;

   logic                            clk = 1'b0;
   logic                            nreset;
   logic                            clear;
   logic [`PK_BYTE_W-1:0]           din;
   logic                            din_valid;
   logic                            flush;
   logic                            hold;
   logic                            in_full;
   logic [$clog2(`PK_FIFO_DEPTH):0] fill_level;
   logic [`PK_DROP_W-1:0]           drop_count;
   logic [`PK_WORD_W-1:0]           dout;
   logic                            dout_valid;
   logic [2:0]                      dout_bytes;

   // ##########################################################
   // reference model state, owned by the monitor
   // ##########################################################
   logic [`PK_WORD_W+2:0]           exp_q[$];          // {bytes, word} in emit order
   logic [`PK_WORD_W+2:0]           exp_word;
   logic [`PK_WORD_W-1:0]           model_acc = '0;    // partial word
   int                              model_lane = 0;    // bytes pending
   logic [`PK_DROP_W-1:0]           model_drops = '0;
   int                              model_words = 0;   // words the model expects overall
   int                              got_words = 0;
   int                              mon_errors = 0;
   logic [$clog2(`PK_FIFO_DEPTH):0] mon_level = '0;    // negedge samples
   logic                            mon_full = 1'b0;
   logic [`PK_DROP_W-1:0]           mon_drops = '0;
   // sequence side counters
   int                              seq_errors = 0;
   int                              timeouts = 0;
   int                              n;

   stream_packer_top dut_i
   (
      .clk        (clk),
      .nreset     (nreset),
      .clear      (clear),
      .din        (din),
      .din_valid  (din_valid),
      .flush      (flush),
      .hold       (hold),
      .in_full    (in_full),
      .fill_level (fill_level),
      .drop_count (drop_count),
      .dout       (dout),
      .dout_valid (dout_valid),
      .dout_bytes (dout_bytes)
   );

   always
   begin
      #4 clk = ~clk;                         // 8 ns period
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp, inout int errs);
      if (got !== exp)
      begin
         errs++;
         $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   // lane packing by the little-endian rules
   task automatic pack_entry(input bit has_byte, input bit last, input logic [7:0] b);
      if (has_byte)
      begin
         model_acc[model_lane*8 +: 8] = b;
         model_lane++;
      end
      if ((model_lane == 4) || last || (!has_byte && (model_lane != 0)))
      begin
         exp_q.push_back({3'(model_lane), model_acc});
         model_words++;
         model_lane = 0;
         model_acc  = '0;
      end
   endtask

   // ##########################################################
   // monitor, samples mid-cycle where everything is stable
   // ##########################################################
   always @(negedge clk)
   begin
      if (nreset)
      begin
         if (dout_valid)
         begin
            got_words++;
            if (exp_q.size() == 0)
            begin
               mon_errors++;
               $display("word 0x%0h appeared on dout while none was expected", dout);
            end
            else
            begin
               exp_word = exp_q.pop_front();
               check_val("dout", dout, exp_word[`PK_WORD_W-1:0], mon_errors);
               check_val("dout_bytes", 32'(dout_bytes), 32'(exp_word[`PK_WORD_W+2 -: 3]),
                         mon_errors);
            end
         end
         if (clear)
         begin
            model_words = model_words - exp_q.size();   // never emitted
            exp_q.delete();
            model_lane  = 0;
            model_acc   = '0;
            model_drops = '0;
         end
         else if (din_valid || flush)
         begin
            if (in_full && (model_drops != '1))
               model_drops = model_drops + 1'b1;    // refused at this edge
            else if (!in_full)
               pack_entry(din_valid, din_valid && flush, din);
         end
         mon_level = fill_level;
         mon_full  = in_full;
         mon_drops = drop_count;
      end
   end

   // ##########################################################
   // stimulus helpers
   // ##########################################################
   task automatic drive_beat(input bit v, input bit f, input logic [7:0] b);
      @(posedge clk);
      din_valid <= v;
      flush     <= f;
      din       <= b;
   endtask

   task automatic random_beats(input int cnt, input int valid_per16, input int flush_per16,
                               input bit rand_hold);
      logic [31:0] r;
      int          i;
      for (i = 0; i < cnt; i++)
      begin
         r = $urandom;
         drive_beat(int'(r[3:0]) < valid_per16, int'(r[7:4]) < flush_per16, r[15:8]);
         if (rand_hold)
            hold <= (r[17:16] == 2'd0);      // high about a quarter of cycles
      end
   endtask

   task automatic set_hold(input bit v);
      @(posedge clk);
      hold <= v;
   endtask

   // idle input, release hold, wait for fifo and expected words to empty
   task automatic wait_drain(input string what);
      drive_beat(1'b0, 1'b0, '0);
      hold <= 1'b0;
      n = 0;
      while (((exp_q.size() != 0) || (mon_level != 0)) && (n < 500))
      begin
         @(posedge clk);
         n++;
      end
      if (n >= 500)
      begin
         timeouts++;
         $display("timeout while waiting for the drain after %s", what);
      end
      repeat (3) @(posedge clk);             // in-flight reads settle
   endtask

   initial
   begin
      void'($urandom(32'h6a23b8ae));
      nreset    = 1'b0;
      clear     = 1'b0;
      din       = '0;
      din_valid = 1'b0;
      flush     = 1'b0;
      hold      = 1'b0;
      repeat (16) @(posedge clk);
      nreset <= 1'b1;

      // full words only, then a flush with and without pending bytes
      random_beats(200, 12, 0, 1'b0);
      wait_drain("plain bytes");
      drive_beat(1'b0, 1'b1, '0);
      drive_beat(1'b0, 1'b1, '0);            // nothing pending here
      wait_drain("bare flushes");

      // mixed opcodes with random hold
      random_beats(300, 10, 3, 1'b1);
      wait_drain("mixed opcodes");

      // ##########################################################
      // long hold, fifo fills and drops
      // ##########################################################
      set_hold(1'b1);
      n = 0;
      while (!mon_full && (n < 64))
      begin
         random_beats(1, 16, 2, 1'b0);
         n++;
      end
      if (!mon_full)
      begin
         timeouts++;
         $display("timeout while waiting for in_full to rise under hold");
      end
      check_val("fill_level", 32'(mon_level), `PK_FIFO_DEPTH, seq_errors);
      random_beats(8 + int'($urandom % 24), 16, 2, 1'b0);
      drive_beat(1'b0, 1'b0, '0);
      repeat (2) @(posedge clk);
      check_val("drop_count", 32'(mon_drops), 32'(model_drops), seq_errors);
      set_hold(1'b0);
      wait_drain("hold release");

      // ##########################################################
      // clear with a loaded fifo and a partial word
      // ##########################################################
      set_hold(1'b1);
      random_beats(12 + int'($urandom % 8), 14, 2, 1'b0);
      drive_beat(1'b0, 1'b0, '0);
      @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      repeat (2) @(posedge clk);
      check_val("fill_level", 32'(mon_level), 0, seq_errors);
      check_val("drop_count", 32'(mon_drops), 0, seq_errors);
      check_val("in_full", 32'(mon_full), 0, seq_errors);
      set_hold(1'b0);
      random_beats(150, 12, 2, 1'b1);
      wait_drain("final stream");

      // end of run totals
      check_val("word count", got_words, model_words, seq_errors);
      check_val("drop_count", 32'(mon_drops), 32'(model_drops), seq_errors);
      check_val("unmatched words", exp_q.size(), 0, seq_errors);
      $display("words %0d, output errors %0d, sequence errors %0d, timeouts %0d",
               got_words, mon_errors, seq_errors, timeouts);
      if ((mon_errors + seq_errors + timeouts) == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- tb/stream_packer_sva.sv
// protocol assertions for the stream packer, attached to the top level with bind
`timescale 1ns/1ps
`include "packer_consts.svh"

module stream_packer_sva
(
   input logic                            clk,
   input logic                            nreset,
   input logic                            clear,       // sync clear pulse
   input logic                            hold,        // downstream back-pressure
   input logic                            dout_valid,
   input logic [2:0]                      dout_bytes,
   input logic                            in_full,     // fifo full flag
   input logic [$clog2(`PK_FIFO_DEPTH):0] fill_level   // fifo occupancy
);

   // ##########################################################
   // output side
   // ##########################################################
   a_no_word_in_reset : assert property (@(posedge clk) !nreset |-> !dout_valid)
      else $error("dout_valid high while nreset is asserted");

   a_byte_count_range : assert property (@(posedge clk) disable iff (!nreset)
      dout_valid |-> ((dout_bytes >= 3'd1) && (dout_bytes <= 3'd4)))
      else $error("dout_bytes 0x%0h out of range with dout_valid", dout_bytes);

   // ##########################################################
   // fifo occupancy
   // ##########################################################
   // a write taken while full would grow the count past the flag
   a_no_write_full : assert property (@(posedge clk) disable iff (!nreset)
      in_full |=> (fill_level <= $past(fill_level)))
      else $error("fifo occupancy grew while full");

   // no read under hold, so only clear may shrink the count
   a_no_read_hold : assert property (@(posedge clk) disable iff (!nreset)
      (hold && !clear) |=> (fill_level >= $past(fill_level)))
      else $error("fifo drained while hold is high");

endmodule

bind stream_packer_top stream_packer_sva sva_i
(
   .clk        (clk),
   .nreset     (nreset),
   .clear      (clear),
   .hold       (hold),
   .dout_valid (dout_valid),
   .dout_bytes (dout_bytes),
   .in_full    (in_full),
   .fill_level (fill_level)
);

//--- design/stream_packer_top.sv
// top level of the byte-to-word stream packer, connects ingress, fifo and word packer
`timescale 1ns/1ps
`include "packer_consts.svh"

module stream_packer_top
(
   input  logic                               clk,
   input  logic                               nreset,     // async, active low
   input  logic                               clear,      // sync clear pulse
   input  logic [`PK_BYTE_W-1:0]              din,
   input  logic                               din_valid,  // byte strobe
   input  logic                               flush,      // end of stream pulse
   input  logic                               hold,       // back-pressure level
   output logic                               in_full,    // fifo full level
   output logic [$clog2(`PK_FIFO_DEPTH):0]    fill_level, // fifo occupancy
   output logic [`PK_DROP_W-1:0]              drop_count,
   output logic [`PK_WORD_W-1:0]              dout,
   output logic                               dout_valid, // word pulse
   output logic [2:0]                         dout_bytes  // 1 to 4
);

   // ##########################################################
   // fifo side wires
   // ##########################################################
   logic                           fifo_wr_en;
   logic [packer_pkg::ENTRY_W-1:0] fifo_wr_data;
   logic                           fifo_rd_en;
   logic [packer_pkg::ENTRY_W-1:0] fifo_rd_data;
   logic                           fifo_empty;

   byte_ingress ingress_i
   (
      .clk        (clk),
      .nreset     (nreset),
      .clear      (clear),
      .din        (din),
      .din_valid  (din_valid),
      .flush      (flush),
      .full       (in_full),              // same flag seen outside
      .wr_en      (fifo_wr_en),
      .wr_data    (fifo_wr_data),
      .drop_count (drop_count)
   );

   fifo_sync
   #(
      .WIDTH (packer_pkg::ENTRY_W),
      .DEPTH (`PK_FIFO_DEPTH)
   )
   fifo_i
   (
      .clk     (clk),
      .nreset  (nreset),
      .clear   (clear),
      .wr_en   (fifo_wr_en),
      .wr_data (fifo_wr_data),
      .full    (in_full),
      .count   (fill_level),
      .rd_en   (fifo_rd_en),
      .rd_data (fifo_rd_data),
      .empty   (fifo_empty)
   );

   word_packer packer_i
   (
      .clk        (clk),
      .nreset     (nreset),
      .clear      (clear),
      .hold       (hold),
      .empty      (fifo_empty),
      .rd_data    (fifo_rd_data),
      .rd_en      (fifo_rd_en),
      .dout       (dout),
      .dout_valid (dout_valid),
      .dout_bytes (dout_bytes)
   );

endmodule

//--- design/word_packer.sv
// output side of the packer, drains fifo entries and assembles little-endian words
`timescale 1ns/1ps
`include "packer_consts.svh"

module word_packer
(
   input  logic                           clk,
   input  logic                           nreset,     // async, active low
   input  logic                           clear,      // drops in-flight and partial data
   input  logic                           hold,       // downstream back-pressure level
   input  logic                           empty,      // fifo empty flag
   input  logic [packer_pkg::ENTRY_W-1:0] rd_data,    // entry, one cycle after rd_en
   output logic                           rd_en,      // fifo read
   output logic [`PK_WORD_W-1:0]          dout,       // packed word
   output logic                           dout_valid, // one cycle pulse
   output logic [2:0]                     dout_bytes  // bytes in dout, 1 to 4
);

   localparam int LANES = `PK_WORD_W / `PK_BYTE_W;   // 4 byte lanes
   localparam int LW    = $clog2(LANES);             // lane counter width

   logic                    rd_vld;        // rd_data holds a fresh entry
   logic [LW-1:0]           lane;          // next free lane
   logic [`PK_WORD_W-1:0]   acc;           // partial word, unused lanes zero
   packer_pkg::op_e         op;            // decoded opcode
   logic [`PK_BYTE_W-1:0]   byte_in;       // decoded byte
   logic                    has_byte;      // entry carries a byte
   logic                    emit;          // word complete this entry
   logic [`PK_WORD_W-1:0]   merged;        // acc with the new byte placed
   logic [2:0]              nbytes;        // byte count including new byte

   // ##########################################################
   // read issue
   // ##########################################################
   assign rd_en = ~empty & ~hold;          // may fire every cycle

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_vld <= 1'b0;
      end
      else
      begin
         rd_vld <= rd_en & ~clear;         // data shows next cycle
      end
   end

   // ##########################################################
   // entry decode and lane placement
   // ##########################################################
   assign op      = packer_pkg::op_e'(rd_data[packer_pkg::ENTRY_W-1 -: packer_pkg::OP_W]);
   assign byte_in = rd_data[`PK_BYTE_W-1:0];

   always_comb
   begin
      has_byte = (op == packer_pkg::OP_DATA) || (op == packer_pkg::OP_LAST);
      merged   = acc;
      if (has_byte)
      begin
         merged[lane*`PK_BYTE_W +: `PK_BYTE_W] = byte_in;  // little endian lanes
      end
      nbytes = 3'(lane) + 3'(has_byte);
      emit   = (has_byte && (lane == LW'(LANES-1)))        // fourth byte
             || (op == packer_pkg::OP_LAST)                 // stream end with byte
             || ((op == packer_pkg::OP_FLUSH) && (lane != '0));  // flush with pending
   end

   // ##########################################################
   // accumulator and word output
   // ##########################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         lane       <= '0;
         acc        <= '0;
         dout_valid <= 1'b0;
      end
      else if (clear)
      begin
         lane       <= '0;                 // partial word discarded
         acc        <= '0;
         dout_valid <= 1'b0;
      end
      else
      begin
         dout_valid <= rd_vld & emit;      // single cycle pulse
         if (rd_vld && emit)
         begin
            lane <= '0;                    // start next word
            acc  <= '0;
         end
         else if (rd_vld && has_byte)
         begin
            lane <= lane + 1'b1;
            acc  <= merged;
         end
      end
   end

   // payload registers
   always_ff @(posedge clk)
   begin
      if (rd_vld && emit)
      begin
         dout       <= merged;
         dout_bytes <= nbytes;
      end
   end

endmodule

//--- design/byte_ingress.sv
// input side of the packer, turns byte strobes and flush pulses into fifo entries
`timescale 1ns/1ps
`include "packer_consts.svh"

module byte_ingress
(
   input  logic                          clk,
   input  logic                          nreset,     // async, active low
   input  logic                          clear,      // zeroes the drop counter
   input  logic [`PK_BYTE_W-1:0]         din,        // input byte
   input  logic                          din_valid,  // byte strobe
   input  logic                          flush,      // end of stream pulse
   input  logic                          full,       // fifo cannot take an entry
   output logic                          wr_en,      // fifo write
   output logic [packer_pkg::ENTRY_W-1:0] wr_data,   // {opcode, byte}
   output logic [`PK_DROP_W-1:0]         drop_count  // refused entries, saturating
);

   packer_pkg::op_e      op;               // encoded opcode
   logic [`PK_BYTE_W-1:0] byte_field;      // payload, zero for flush
   logic                  offer;           // an entry exists this cycle

   // ##########################################################
   // entry encoding
   // ##########################################################
   always_comb
   begin
      op         = packer_pkg::OP_DATA;
      byte_field = din;
      if (din_valid && flush)
      begin
         op = packer_pkg::OP_LAST;          // byte closes the stream
      end
      else if (!din_valid)
      begin
         op         = packer_pkg::OP_FLUSH; // bare flush
         byte_field = '0;
      end
   end

   assign offer   = din_valid | flush;
   assign wr_en   = offer & ~full;         // only when there is room
   assign wr_data = {op, byte_field};

   // ##########################################################
   // drop counter
   // ##########################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         drop_count <= '0;
      end
      else if (clear)
      begin
         drop_count <= '0;
      end
      else if (offer && full && (drop_count != '1))
      begin
         drop_count <= drop_count + 1'b1;   // holds at all ones
      end
   end

endmodule

//--- design/fifo_sync.sv
// single-clock fifo with wrap-bit pointers, occupancy count and sync clear around dual_port_ram
`timescale 1ns/1ps

module fifo_sync
#(
   parameter int WIDTH = 8,                // entry width
   parameter int DEPTH = 8                 // entries, power of two
)
(
   input  logic                     clk,
   input  logic                     nreset,   // async, active low
   input  logic                     clear,    // sync clear of pointers and count
   // write side
   input  logic                     wr_en,
   input  logic [WIDTH-1:0]         wr_data,
   output logic                     full,
   output logic [$clog2(DEPTH):0]   count,    // 0 .. DEPTH
   // read side
   input  logic                     rd_en,
   output logic [WIDTH-1:0]         rd_data,  // entry one cycle after rd_en
   output logic                     empty
);

   localparam int AW = $clog2(DEPTH);      // address bits

   // ##########################################################
   // pointers and flags
   // ##########################################################
   logic [AW:0] wr_ptr;                    // msb is the wrap bit
   logic [AW:0] rd_ptr;                    // msb is the wrap bit
   logic        addr_match;                // low bits equal
   logic        fifo_write;                // accepted write
   logic        fifo_read;                 // accepted read

   assign addr_match = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign full       = addr_match & (wr_ptr[AW] != rd_ptr[AW]);   // writer lapped reader
   assign empty      = addr_match & (wr_ptr[AW] == rd_ptr[AW]);   // same lap

   assign fifo_write = wr_en & ~full;      // write on full is dropped
   assign fifo_read  = rd_en & ~empty;     // read on empty is ignored

   // pointer update
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else if (clear)
      begin
         wr_ptr <= '0;                      // back to empty
         rd_ptr <= '0;
      end
      else
      begin
         if (fifo_write)
         begin
            wr_ptr <= wr_ptr + 1'b1;        // wraps through the msb
         end
         if (fifo_read)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // ##########################################################
   // occupancy count
   // ##########################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         count <= '0;
      end
      else if (clear)
      begin
         count <= '0;
      end
      else if (fifo_write & ~fifo_read)
      begin
         count <= count + 1'b1;             // one more stored
      end
      else if (fifo_read & ~fifo_write)
      begin
         count <= count - 1'b1;             // one drained
      end
   end

   // ##########################################################
   // memory array
   // ##########################################################
   dual_port_ram
   #(
      .WIDTH (WIDTH),
      .DEPTH (DEPTH)
   )
   ram_i
   (
      .clk     (clk),
      .wr_en   (fifo_write),
      .wr_addr (wr_ptr[AW-1:0]),
      .wr_data (wr_data),
      .rd_en   (fifo_read),
      .rd_addr (rd_ptr[AW-1:0]),
      .rd_data (rd_data)
   );

endmodule

//--- design/dual_port_ram.sv
// register-array memory with one write and one registered read port, used as the fifo store
`timescale 1ns/1ps

module dual_port_ram
#(
   parameter int WIDTH = 8,                // word width
   parameter int DEPTH = 8                 // number of words
)
(
   input  logic                     clk,
   input  logic                     wr_en,    // write strobe
   input  logic [$clog2(DEPTH)-1:0] wr_addr,
   input  logic [WIDTH-1:0]         wr_data,
   input  logic                     rd_en,    // read strobe
   input  logic [$clog2(DEPTH)-1:0] rd_addr,
   output logic [WIDTH-1:0]         rd_data   // valid the cycle after rd_en
);

   logic [WIDTH-1:0] mem [DEPTH];          // storage array

   // write port
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;           // lands on this edge
      end
   end

   // read port, output register holds its value between reads
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         rd_data <= mem[rd_addr];           // one cycle latency
      end
   end

endmodule

//--- design/packer_pkg.sv
// shared types for the stream packer, referenced by scoped name from ingress and packer
`include "packer_consts.svh"

package packer_pkg;

   // ##########################################################
   // fifo entry opcode
   // ##########################################################
   typedef enum logic [1:0]
   {
      OP_DATA  = 2'd0,     // plain byte
      OP_LAST  = 2'd1,     // byte that closes the stream
      OP_FLUSH = 2'd2      // no byte, closes the stream
   } op_e;

   localparam int OP_W = $bits(op_e);            // opcode field width

   // entry layout is {opcode, byte}
   localparam int ENTRY_W = OP_W + `PK_BYTE_W;   // 10 bits with 8 bit bytes

endpackage

//--- include/packer_consts.svh
// sizing macros for the stream packer, included by every file that needs widths or depth
`ifndef PACKER_CONSTS_SVH
`define PACKER_CONSTS_SVH

// ##########################################################
// data widths
// ##########################################################
`define PK_BYTE_W 8        // one input byte
`define PK_WORD_W 32       // packed output word

// ##########################################################
// buffering and statistics
// ##########################################################
`define PK_FIFO_DEPTH 8    // entries, power of two
`define PK_DROP_W 16       // saturating drop counter

`endif
